// ==== ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    localparam int XLEN      = 32; // datapath width
    localparam int NUM_REGS  = 32; // architectural registers
    localparam int REG_W     = 5;  // register index bits
    localparam int ROB_DEPTH = 8;  // reorder buffer entries
    localparam int TAG_W     = 3;  // rob tag bits
    localparam int ALU_LAT   = 2;  // accept edge to cdb pulse

    // alu opcodes, addi swaps operand b for the immediate
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5
    } alu_op_t;

    // issue unit to alu
    typedef struct packed {
        logic             valid; // packet carries an accepted instruction
        logic [TAG_W-1:0] tag;   // rob slot of the result
        alu_op_t          op;
        logic [XLEN-1:0]  a;     // resolved operand a
        logic [XLEN-1:0]  b;     // resolved operand b or immediate
    } issue_pkt_t;

    // one reorder buffer slot
    typedef struct packed {
        logic             busy;  // slot holds an instruction
        logic             done;  // result came back on the cdb
        logic [REG_W-1:0] dest;  // architectural destination
        logic [XLEN-1:0]  value; // result waiting for commit
    } rob_entry_t;

endpackage : ooo_pkg

`default_nettype wire

// ==== ooo_ifs.sv ====
`timescale 1ns/1ns
`default_nettype none

// source operand read, issue unit asks and regfile answers in the same cycle
interface rf_read_if;
    logic [ooo_pkg::REG_W-1:0] src_a, src_b;   // source register indices
    logic [ooo_pkg::XLEN-1:0]  reg_a, reg_b;   // register data, forwarded on commit
    logic                      valid_a, valid_b; // data is current
    logic [ooo_pkg::TAG_W-1:0] tag_a, tag_b;   // pending producer when not valid

    modport issue   (output src_a, src_b, input reg_a, reg_b, valid_a, valid_b, tag_a, tag_b);
    modport regfile (input src_a, src_b, output reg_a, reg_b, valid_a, valid_b, tag_a, tag_b);
endinterface : rf_read_if

// operand lookup into the rob plus its allocation status
interface rob_read_if;
    logic [ooo_pkg::TAG_W-1:0] look_tag_a, look_tag_b; // producer tags from regfile
    logic                      done_a, done_b;         // producer finished
    logic [ooo_pkg::XLEN-1:0]  value_a, value_b;       // producer result
    logic                      full;                   // no free slot
    logic [ooo_pkg::TAG_W-1:0] alloc_tag;              // current tail

    modport issue (output look_tag_a, look_tag_b,
                   input done_a, done_b, value_a, value_b, full, alloc_tag);
    modport rob   (input look_tag_a, look_tag_b,
                   output done_a, done_b, value_a, value_b, full, alloc_tag);
endinterface : rob_read_if

// retirement strobe, one cycle per committed instruction
interface commit_if;
    logic                      load;  // head retires this cycle
    logic [ooo_pkg::REG_W-1:0] dest;  // register to write
    logic [ooo_pkg::TAG_W-1:0] tag;   // retiring slot
    logic [ooo_pkg::XLEN-1:0]  value; // result

    modport source (output load, dest, tag, value);
    modport sink   (input load, dest, tag, value);
endinterface : commit_if

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  wire logic                      clk,
    input  wire logic                      rst,
    rf_read_if.regfile                     rd,
    commit_if.sink                         cm,
    input  wire logic                      allocate,     // new producer for alloc_dest
    input  wire logic [ooo_pkg::REG_W-1:0] alloc_dest,
    input  wire logic [ooo_pkg::TAG_W-1:0] alloc_tag,    // rob tail taken by the producer
    input  wire logic [ooo_pkg::REG_W-1:0] arch_rd_addr, // architectural read port
    output logic      [ooo_pkg::XLEN-1:0]  arch_rd_data
);

    logic [ooo_pkg::XLEN-1:0]  data_q  [ooo_pkg::NUM_REGS];
    logic [ooo_pkg::TAG_W-1:0] tag_q   [ooo_pkg::NUM_REGS]; // latest producer per register
    logic                      valid_q [ooo_pkg::NUM_REGS]; // low while a producer is in flight

    logic cm_wr;    // commit to a real register
    logic alloc_wr; // allocate to a real register
    logic hit_a;    // commit targets source a this cycle
    logic hit_b;

    assign cm_wr    = cm.load && (cm.dest != '0);
    assign alloc_wr = allocate && (alloc_dest != '0); // r0 keeps tag 0 and stays valid

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ooo_pkg::NUM_REGS; i++) begin
                data_q[i]  <= '0;
                tag_q[i]   <= '0;
                valid_q[i] <= 1'b1;
            end
        end else begin
            if (cm_wr) begin
                data_q[cm.dest] <= cm.value;
                if (tag_q[cm.dest] == cm.tag) // older producer leaves the register pending
                    valid_q[cm.dest] <= 1'b1;
            end
            // allocate wins on a shared register, the data above still lands
            if (alloc_wr) begin
                valid_q[alloc_dest] <= 1'b0;
                tag_q[alloc_dest]   <= alloc_tag;
            end
        end
    end

    assign hit_a = cm_wr && (cm.dest == rd.src_a);
    assign hit_b = cm_wr && (cm.dest == rd.src_b);

    always_comb begin
        rd.tag_a = tag_q[rd.src_a];
        rd.tag_b = tag_q[rd.src_b];

        if (rd.src_a == '0) begin
            rd.reg_a   = '0; // r0 is hardwired
            rd.valid_a = 1'b1;
        end else if (hit_a) begin
            rd.reg_a   = cm.value; // forward the retiring result
            rd.valid_a = valid_q[rd.src_a] || (tag_q[rd.src_a] == cm.tag);
        end else begin
            rd.reg_a   = data_q[rd.src_a];
            rd.valid_a = valid_q[rd.src_a];
        end

        if (rd.src_b == '0) begin
            rd.reg_b   = '0;
            rd.valid_b = 1'b1;
        end else if (hit_b) begin
            rd.reg_b   = cm.value;
            rd.valid_b = valid_q[rd.src_b] || (tag_q[rd.src_b] == cm.tag);
        end else begin
            rd.reg_b   = data_q[rd.src_b];
            rd.valid_b = valid_q[rd.src_b];
        end
    end

    assign arch_rd_data = (arch_rd_addr == '0) ? '0 : data_q[arch_rd_addr];

    // the latest producer of a register retires only while that register is still pending
    a_commit_pending: assert property (@(posedge clk) disable iff (rst)
        (cm_wr && tag_q[cm.dest] == cm.tag) |-> !valid_q[cm.dest]);

endmodule : regfile

`default_nettype wire

// ==== rob.sv ====
`timescale 1ns/1ns
`default_nettype none

module rob (
    input  wire logic                      clk,
    input  wire logic                      rst,
    rob_read_if.rob                        lk,
    input  wire logic                      allocate,   // accept from issue, takes the tail
    input  wire logic [ooo_pkg::REG_W-1:0] alloc_dest,
    input  wire logic                      cdb_valid,  // result broadcast from the alu
    input  wire logic [ooo_pkg::TAG_W-1:0] cdb_tag,
    input  wire logic [ooo_pkg::XLEN-1:0]  cdb_value,
    commit_if.source                       cm
);

    ooo_pkg::rob_entry_t entries [ooo_pkg::ROB_DEPTH]; // busy and done reset, payload not

    logic [ooo_pkg::TAG_W-1:0] head_q;  // oldest instruction
    logic [ooo_pkg::TAG_W-1:0] tail_q;  // next free slot
    logic [ooo_pkg::TAG_W:0]   count_q; // occupied slots, one bit wider for full
    logic                      retire;  // head leaves this cycle

    assign retire = entries[head_q].busy && entries[head_q].done;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < ooo_pkg::ROB_DEPTH; i++) begin
                entries[i].busy <= 1'b0;
                entries[i].done <= 1'b0;
            end
        end else begin
            if (allocate) begin
                entries[tail_q].busy  <= 1'b1;
                entries[tail_q].done  <= 1'b0;
                entries[tail_q].dest  <= alloc_dest;
                tail_q                <= tail_q + 1'b1; // power of two depth wraps by itself
            end
            if (cdb_valid) begin
                entries[cdb_tag].done  <= 1'b1;
                entries[cdb_tag].value <= cdb_value;
            end
            if (retire) begin
                entries[head_q].busy <= 1'b0;
                head_q               <= head_q + 1'b1;
            end
            // the three slots never overlap, tail is free, cdb slot is not done, head is
            case ({allocate, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_comb begin
        lk.full      = (count_q == ooo_pkg::ROB_DEPTH);
        lk.alloc_tag = tail_q;
        // operand bypass for a pending register whose producer already finished
        lk.done_a    = entries[lk.look_tag_a].busy && entries[lk.look_tag_a].done;
        lk.done_b    = entries[lk.look_tag_b].busy && entries[lk.look_tag_b].done;
        lk.value_a   = entries[lk.look_tag_a].value;
        lk.value_b   = entries[lk.look_tag_b].value;
    end

    always_comb begin
        cm.load  = retire; // one strobe per retirement, in program order
        cm.dest  = entries[head_q].dest;
        cm.tag   = head_q;
        cm.value = entries[head_q].value;
    end

    // issue has to honour full through its stall output
    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        allocate |-> !lk.full);

    // alu must only complete slots that were allocated and are still open
    a_cdb_open_slot: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> (entries[cdb_tag].busy && !entries[cdb_tag].done));

endmodule : rob

`default_nettype wire

// ==== issue_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_unit (
    input  wire logic                      instr_valid, // instruction presented
    input  wire ooo_pkg::alu_op_t          instr_op,
    input  wire logic [ooo_pkg::REG_W-1:0] instr_dest,
    input  wire logic [ooo_pkg::REG_W-1:0] instr_src_a,
    input  wire logic [ooo_pkg::REG_W-1:0] instr_src_b,
    input  wire logic [11:0]               instr_imm,   // addi immediate, sign extended
    output logic                           stall,       // instruction not taken this cycle
    rf_read_if.issue                       rd,
    rob_read_if.issue                      lk,
    output logic                           allocate,
    output logic      [ooo_pkg::REG_W-1:0] alloc_dest,
    output ooo_pkg::issue_pkt_t            pkt
);

    logic                     use_b;  // operand b comes from a register
    logic                     wait_a; // producer of a still executing
    logic                     wait_b;
    logic [ooo_pkg::XLEN-1:0] opnd_a;
    logic [ooo_pkg::XLEN-1:0] opnd_b;
    logic [ooo_pkg::XLEN-1:0] imm_ext;
    logic                     accept;

    assign rd.src_a = instr_src_a;
    assign rd.src_b = instr_src_b;
    assign lk.look_tag_a = rd.tag_a; // only meaningful when the register is pending
    assign lk.look_tag_b = rd.tag_b;

    assign use_b   = (instr_op != ooo_pkg::OP_ADDI);
    assign imm_ext = {{(ooo_pkg::XLEN - 12){instr_imm[11]}}, instr_imm};

    assign wait_a = !rd.valid_a && !lk.done_a;
    assign wait_b = use_b && !rd.valid_b && !lk.done_b; // addi ignores src_b

    assign opnd_a = rd.valid_a ? rd.reg_a : lk.value_a;
    assign opnd_b = !use_b     ? imm_ext  :
                    rd.valid_b ? rd.reg_b : lk.value_b;

    // full blocks even an idle input, operand waits only matter with an instruction
    assign stall  = lk.full || (instr_valid && (wait_a || wait_b));
    assign accept = instr_valid && !stall;

    // dest 0 still takes a rob slot, regfile drops its allocate and commit
    assign allocate   = accept;
    assign alloc_dest = instr_dest;

    always_comb begin
        pkt.valid = accept;
        pkt.tag   = lk.alloc_tag; // result returns on this tag
        pkt.op    = instr_op;
        pkt.a     = opnd_a;
        pkt.b     = opnd_b;
    end

endmodule : issue_unit

`default_nettype wire

// ==== alu_pipe.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_pipe (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire ooo_pkg::issue_pkt_t       pkt,       // from issue, valid on the accept edge
    output logic                           cdb_valid, // one cycle result pulse
    output logic      [ooo_pkg::TAG_W-1:0] cdb_tag,
    output logic      [ooo_pkg::XLEN-1:0]  cdb_value
);

    logic [ooo_pkg::XLEN-1:0]  result;
    logic                      s1_valid; // stage one holds the computed result
    logic [ooo_pkg::TAG_W-1:0] s1_tag;
    logic [ooo_pkg::XLEN-1:0]  s1_value;

    always_comb begin
        case (pkt.op)
            ooo_pkg::OP_ADD,
            ooo_pkg::OP_ADDI: result = pkt.a + pkt.b; // b already holds the immediate
            ooo_pkg::OP_SUB:  result = pkt.a - pkt.b;
            ooo_pkg::OP_AND:  result = pkt.a & pkt.b;
            ooo_pkg::OP_OR:   result = pkt.a | pkt.b;
            ooo_pkg::OP_XOR:  result = pkt.a ^ pkt.b;
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            cdb_valid <= 1'b0;
        end else begin
            s1_valid  <= pkt.valid;
            cdb_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag    <= pkt.tag;
        s1_value  <= result;
        cdb_tag   <= s1_tag;   // stage two drives the cdb straight from flops
        cdb_value <= s1_value;
    end

    a_legal_op: assert property (@(posedge clk) disable iff (rst)
        pkt.valid |-> (pkt.op inside {ooo_pkg::OP_ADD, ooo_pkg::OP_SUB, ooo_pkg::OP_AND,
                                      ooo_pkg::OP_OR, ooo_pkg::OP_XOR, ooo_pkg::OP_ADDI}));

endmodule : alu_pipe

`default_nettype wire

// ==== ooo_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module ooo_core (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      instr_valid,
    input  wire ooo_pkg::alu_op_t          instr_op,
    input  wire logic [ooo_pkg::REG_W-1:0] instr_dest,
    input  wire logic [ooo_pkg::REG_W-1:0] instr_src_a,
    input  wire logic [ooo_pkg::REG_W-1:0] instr_src_b,
    input  wire logic [11:0]               instr_imm,
    input  wire logic [ooo_pkg::REG_W-1:0] arch_rd_addr,
    output logic                           stall,
    output logic      [ooo_pkg::XLEN-1:0]  arch_rd_data,
    output logic                           commit_valid, // retirement strobe
    output logic      [ooo_pkg::REG_W-1:0] commit_dest,
    output logic      [ooo_pkg::XLEN-1:0]  commit_value
);

    rf_read_if  rf_rd ();
    rob_read_if rob_lk ();
    commit_if   cm ();

    logic                      allocate;
    logic [ooo_pkg::REG_W-1:0] alloc_dest;
    ooo_pkg::issue_pkt_t       pkt;
    logic                      cdb_valid;
    logic [ooo_pkg::TAG_W-1:0] cdb_tag;
    logic [ooo_pkg::XLEN-1:0]  cdb_value;

    issue_unit u_issue (
        .instr_valid (instr_valid),
        .instr_op    (instr_op),
        .instr_dest  (instr_dest),
        .instr_src_a (instr_src_a),
        .instr_src_b (instr_src_b),
        .instr_imm   (instr_imm),
        .stall       (stall),
        .rd          (rf_rd.issue),
        .lk          (rob_lk.issue),
        .allocate    (allocate),
        .alloc_dest  (alloc_dest),
        .pkt         (pkt)
    );

    regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .rd           (rf_rd.regfile),
        .cm           (cm.sink),
        .allocate     (allocate),
        .alloc_dest   (alloc_dest),
        .alloc_tag    (rob_lk.alloc_tag), // same tail the packet carries
        .arch_rd_addr (arch_rd_addr),
        .arch_rd_data (arch_rd_data)
    );

    rob u_rob (
        .clk        (clk),
        .rst        (rst),
        .lk         (rob_lk.rob),
        .allocate   (allocate),
        .alloc_dest (alloc_dest),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value),
        .cm         (cm.source)
    );

    alu_pipe u_alu (
        .clk       (clk),
        .rst       (rst),
        .pkt       (pkt),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value)
    );

    assign commit_valid = cm.load;
    assign commit_dest  = cm.dest;
    assign commit_value = cm.value;

endmodule : ooo_core

`default_nettype wire

// ==== tb_ooo_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_ooo_core;

    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 16;
    localparam int MAX_INSTR  = 64; // program storage

    logic                      clk;
    logic                      rst;
    logic                      instr_valid;
    ooo_pkg::alu_op_t          instr_op;
    logic [ooo_pkg::REG_W-1:0] instr_dest;
    logic [ooo_pkg::REG_W-1:0] instr_src_a;
    logic [ooo_pkg::REG_W-1:0] instr_src_b;
    logic [11:0]               instr_imm;
    logic [ooo_pkg::REG_W-1:0] arch_rd_addr;
    logic                      stall;
    logic [ooo_pkg::XLEN-1:0]  arch_rd_data;
    logic                      commit_valid;
    logic [ooo_pkg::REG_W-1:0] commit_dest;
    logic [ooo_pkg::XLEN-1:0]  commit_value;

    logic [2:0]                prog_op   [MAX_INSTR]; // program as read from the file
    logic [ooo_pkg::REG_W-1:0] prog_dest [MAX_INSTR];
    logic [ooo_pkg::REG_W-1:0] prog_src_a [MAX_INSTR];
    logic [ooo_pkg::REG_W-1:0] prog_src_b [MAX_INSTR];
    logic [11:0]               prog_imm  [MAX_INSTR];
    logic [ooo_pkg::XLEN-1:0]  prog_val  [MAX_INSTR]; // result of sequential execution
    logic [ooo_pkg::REG_W-1:0] fin_reg   [MAX_INSTR];
    logic [ooo_pkg::XLEN-1:0]  fin_val   [MAX_INSTR];

    logic [ooo_pkg::REG_W-1:0] exp_dest_q [$]; // accepted and not yet committed
    logic [ooo_pkg::XLEN-1:0]  exp_val_q  [$];

    int  ready_at [ooo_pkg::NUM_REGS]; // first cycle the latest producer's result is usable

    int  n_instr      = 0;
    int  n_fin        = 0;
    int  commit_count = 0;
    int  checks       = 0;
    int  errors       = 0;
    int  stall_cycles = 0;
    int  cyc          = 0;    // rising edges seen
    bit  loaded       = 1'b0; // starts the watchdog

    ooo_core UUT (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic load_stim(output bit ok);
        int                    fd;
        int                    n;
        bit                    bad;
        logic [8*16-1:0]       kw;
        logic [8*128-1:0]      line;
        logic [2:0]            op;
        logic [4:0]            dest;
        logic [4:0]            sa;
        logic [4:0]            sb;
        logic [11:0]           imm;
        logic [31:0]           val;
        bad = 1'b0;
        fd  = $fopen("ooo_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = '0;
                kw   = '0;
                n    = $fgets(line, fd);
                n    = $sscanf(line, "%s", kw); // '#' lines and blanks fall through
                if (n == 1 && kw == "I") begin
                    n = $sscanf(line, "%s %d %d %d %d %h %h", kw, op, dest, sa, sb, imm, val);
                    if (n != 7 || n_instr >= MAX_INSTR)
                        bad = 1'b1;
                    else begin
                        prog_op[n_instr]    = op;
                        prog_dest[n_instr]  = dest;
                        prog_src_a[n_instr] = sa;
                        prog_src_b[n_instr] = sb;
                        prog_imm[n_instr]   = imm;
                        prog_val[n_instr]   = val;
                        n_instr++;
                    end
                end else if (n == 1 && kw == "R") begin
                    n = $sscanf(line, "%s %d %h", kw, dest, val);
                    if (n != 3 || n_fin >= MAX_INSTR)
                        bad = 1'b1;
                    else begin
                        fin_reg[n_fin] = dest;
                        fin_val[n_fin] = val;
                        n_fin++;
                    end
                end
            end
            $fclose(fd);
        end
        ok = (fd != 0) && !bad && (n_instr > 0) && (n_fin > 0);
    endtask

    // r0 is always ready, others once the producer's cdb pulse has marked its rob slot done
    function automatic bit operand_ready(input logic [ooo_pkg::REG_W-1:0] r, input int now);
        return (r == '0) || (now >= ready_at[r]);
    endfunction

    // present one instruction and hold it until the core takes it
    task automatic issue_instr(input int i);
        bit taken;
        bit exp_stall;
        int acc_cyc;
        taken = 1'b0;
        acc_cyc = 0;
        @(negedge clk);
        instr_valid = 1'b1;
        instr_op    = ooo_pkg::alu_op_t'(prog_op[i]);
        instr_dest  = prog_dest[i];
        instr_src_a = prog_src_a[i];
        instr_src_b = prog_src_b[i];
        instr_imm   = prog_imm[i];
        while (!taken) begin
            #1;
            exp_stall = !operand_ready(prog_src_a[i], cyc) ||
                        (prog_op[i] != ooo_pkg::OP_ADDI && !operand_ready(prog_src_b[i], cyc));
            acc_cyc   = cyc + 1; // edge that takes the instruction if stall is low
            checks++;
            assert (stall == exp_stall) else begin
                errors++;
                $display("[ERROR] %0t: instruction %0d sees stall %b, expected %b",
                         $time, i, stall, exp_stall);
            end
            taken = !stall; // stall is settled until the rising edge
            @(posedge clk);
            if (!taken) begin
                stall_cycles++;
                @(negedge clk);
            end
        end
        if (prog_dest[i] != '0)
            ready_at[prog_dest[i]] = acc_cyc + ooo_pkg::ALU_LAT;
        exp_dest_q.push_back(prog_dest[i]);
        exp_val_q.push_back(prog_val[i]);
    endtask

    // architectural read port, one register per cycle
    task automatic check_regs();
        for (int k = 0; k < n_fin; k++) begin
            @(negedge clk);
            arch_rd_addr = fin_reg[k];
            #1;
            checks++;
            assert (arch_rd_data == fin_val[k]) else begin
                errors++;
                $display("[ERROR] %0t: r%0d reads %h, expected %h",
                         $time, fin_reg[k], arch_rd_data, fin_val[k]);
            end
        end
    endtask

    task automatic print_summary();
        $display("checks %0d  errors %0d  commits %0d of %0d  stall cycles %0d",
                 checks, errors, commit_count, n_instr, stall_cycles);
    endtask

    // commit outputs come from rob state only, so the falling edge sees them settled
    always @(negedge clk) begin : commit_monitor
        logic [ooo_pkg::REG_W-1:0] e_dest;
        logic [ooo_pkg::XLEN-1:0]  e_val;
        if (!rst && commit_valid) begin
            assert (exp_dest_q.size() > 0) else begin
                errors++;
                $display("a commit to r%0d at %0t came with no instruction outstanding",
                         commit_dest, $time);
            end
            if (exp_dest_q.size() > 0) begin
                e_dest = exp_dest_q.pop_front(); // program order
                e_val  = exp_val_q.pop_front();
                checks++;
                assert (commit_dest == e_dest && commit_value == e_val) else begin
                    errors++;
                    $display("[ERROR] %0t: commit %0d wrote r%0d = %h, expected r%0d = %h",
                             $time, commit_count, commit_dest, commit_value, e_dest, e_val);
                end
            end
            commit_count++;
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (RST_CYCLES + 20 * n_instr + 200) @(posedge clk);
        $display("the run timed out with %0d of %0d instructions committed",
                 commit_count, n_instr);
        errors++;
        print_summary();
        $display("Done: errors found");
        $finish;
    end

    initial begin
        bit ok;
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr_op     = ooo_pkg::OP_ADD;
        instr_dest   = '0;
        instr_src_a  = '0;
        instr_src_b  = '0;
        instr_imm    = '0;
        arch_rd_addr = '0;
        load_stim(ok);
        loaded = 1'b1;
        if (!ok) begin
            errors++;
            $display("ooo_stim.txt is missing or holds a line that does not parse");
        end else begin
            $display("%0d instructions, %0d register checks, rob entry of %0d bits",
                     n_instr, n_fin, $bits(ooo_pkg::rob_entry_t));
            repeat (RST_CYCLES) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            for (int i = 0; i < n_instr; i++)
                issue_instr(i);
            @(negedge clk);
            instr_valid = 1'b0;
            wait (commit_count == n_instr); // watchdog covers a lost commit
            repeat (2) @(negedge clk);
            check_regs();
            assert (commit_count == n_instr && exp_dest_q.size() == 0) else begin
                errors++;
                $display("%0d commits seen for %0d instructions", commit_count, n_instr);
            end
        end
        print_summary();
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule : tb_ooo_core

`default_nettype wire

// ==== build.f ====
ooo_pkg.sv
ooo_ifs.sv
regfile.sv
rob.sv
issue_unit.sv
alu_pipe.sv
ooo_core.sv
tb_ooo_core.sv

// ==== ooo_stim.txt ====
# I op dest src_a src_b imm expected_commit with imm and values in hex
# op codes are 0 add 1 sub 2 and 3 or 4 xor 5 addi
# dependent chain through rob and commit forwarding
I 5 1 0 0 123 00000123
I 5 2 1 0 7ff 00000922
I 0 3 1 2 000 00000a45
I 1 4 3 2 000 00000123
I 5 5 0 0 fff ffffffff
I 4 6 5 3 000 fffff5ba
I 2 7 6 2 000 00000122
# two writes in flight to r9 and then a reader
I 5 9 0 0 011 00000011
I 5 9 0 0 022 00000022
I 0 10 9 9 000 00000044
I 1 11 4 3 000 fffff6de
# r0 as destination and as source
I 5 0 1 0 001 00000124
I 0 12 0 1 000 00000123
I 3 13 7 0 000 00000122
# nine independent addi
I 5 14 0 0 001 00000001
I 5 15 0 0 002 00000002
I 5 16 0 0 003 00000003
I 5 17 0 0 004 00000004
I 5 18 0 0 005 00000005
I 5 19 0 0 006 00000006
I 5 20 0 0 007 00000007
I 5 21 0 0 008 00000008
I 5 22 0 0 800 fffff800
I 0 23 22 21 000 fffff808
I 4 24 23 5 000 000007f7
# R reg final_value read back through the architectural port
R 0 00000000
R 1 00000123
R 2 00000922
R 3 00000a45
R 4 00000123
R 5 ffffffff
R 6 fffff5ba
R 7 00000122
R 9 00000022
R 10 00000044
R 11 fffff6de
R 12 00000123
R 13 00000122
R 21 00000008
R 22 fffff800
R 23 fffff808
R 24 000007f7
R 31 00000000
